//--- vlog.f
rtl/sram_cfg_pkg.sv
rtl/sram_req_pkg.sv
rtl/zbt_req_stage.sv
rtl/zbt_cmd_stage.sv
rtl/zbt_data_stage.sv
rtl/zbt_sram_ctrl.sv
tests/zbt_sram_model.sv
tests/zbt_sram_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the ZBT SRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f vlog.f \
    --top-module zbt_sram_ctrl_tb \
    -o zbt_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/zbt_sim)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

//--- tests/zbt_sram_ctrl_tb.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ZBT SRAM controller testbench
// directed tests against a pipelined SRAM model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module zbt_sram_ctrl_tb
    import sram_cfg_pkg::*;
    import sram_req_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    // rough length of each test in cycles
    localparam int TEST_CYCLES  = 10 + 40 + 90 + 40 + 80;
    localparam int WATCHDOG_NS  = (TEST_CYCLES * 2 + RESET_CYCLES) * CLK_PERIOD;

    logic              clk;
    logic              arst_n;
    logic              req_valid;
    sram_req_t         req;
    logic              req_ready;
    logic              rsp_valid;
    sram_rsp_t         rsp;
    logic              rsp_ready;
    sram_cmd_t         sram_cmd;
    wire  [DATA_W-1:0] sram_data;

    logic [31:0]       lfsr;
    logic [TAG_W-1:0]  next_tag;
    int                errors;
    int                checks;
    logic [DATA_W-1:0] sb [logic [ADDR_W-1:0]];
    sram_rsp_t         exp_q [$];

    zbt_sram_ctrl UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .sram_cmd  (sram_cmd),
        .sram_data (sram_data)
    );

    zbt_sram_model u_sram (
        .clk       (clk),
        .sram_cmd  (sram_cmd),
        .sram_data (sram_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish in %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic sram_req_t make_req(input sram_op_e op, input logic [ADDR_W-1:0] addr,
                                           input logic [DATA_W-1:0] wdata,
                                           input logic [TAG_W-1:0] tag);
        return '{op: op, addr: addr, wdata: wdata, tag: tag};
    endfunction

    task automatic check_rsp(input string name, input sram_rsp_t exp, input sram_rsp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s expected rdata=%h tag=%h actual rdata=%h tag=%h",
                     $time, name, exp.rdata, exp.tag, act.rdata, act.tag);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    // every handshaken response is compared in request order
    always @(posedge clk) begin
        if (arst_n && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("error at %0t: response with no read outstanding", $time);
            end else begin
                check_rsp("rsp", exp_q.pop_front(), rsp);
            end
        end
    end

    task automatic send_req(input sram_req_t r, output int stalls);
        int n;
        n = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req       = r;
        @(posedge clk);
        while (!req_ready && n < 50) begin
            n++;
            @(posedge clk);
        end
        if (!req_ready) begin
            errors++;
            $display("error at %0t: request not accepted within 50 cycles", $time);
        end else if (r.op == OP_READ) begin
            exp_q.push_back(sram_rsp_t'{rdata: sb[r.addr], tag: r.tag});
        end else begin
            sb[r.addr] = r.wdata;
        end
        stalls = n;
    endtask

    task automatic go_idle(input int cycles);
        @(negedge clk);
        req_valid = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic drain_rsp();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 100) begin
            n++;
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("error at %0t: %0d responses never arrived", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic write_new(output logic [ADDR_W-1:0] addr);
        int s;
        addr = rand_bits(ADDR_W);
        send_req(make_req(OP_WRITE, addr, rand_bits(DATA_W), '0), s);
    endtask

    task automatic read_addr(input logic [ADDR_W-1:0] addr, output int stalls);
        send_req(make_req(OP_READ, addr, '0, next_tag), stalls);
        next_tag++;
    endtask

    task automatic test_reset_values();
        int e0;
        e0 = errors;
        check_value("req_ready", 1, req_ready);
        check_value("rsp_valid", 0, rsp_valid);
        check_value("sram_cmd.we_n", 1, sram_cmd.we_n);
        check_value("output enable", 0, UUT.u_data_stage.oe_q);
        $display("test reset_values done, %0d errors", errors - e0);
    endtask

    task automatic test_single_read();
        int e0;
        int s;
        int n;
        logic [ADDR_W-1:0] a;
        e0 = errors;
        rsp_ready = 1'b1;
        write_new(a);
        go_idle(4);
        read_addr(a, s);
        // n counts the accept edge and every edge after it with rsp_valid still low
        n = 0;
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid && n < 20) begin
            n++;
            @(negedge clk);
        end
        check_value("read latency", READ_LATENCY, n);
        drain_rsp();
        $display("test single_read done, %0d errors", errors - e0);
    endtask

    task automatic test_back_to_back();
        int e0;
        int s;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] written [$];
        e0 = errors;
        rsp_ready = 1'b1;
        for (int i = 0; i < 16; i++) begin
            a = rand_bits(ADDR_W);
            written.push_back(a);
            send_req(make_req(OP_WRITE, a, rand_bits(DATA_W), '0), s);
            check_value("req_ready stalls", 0, s);
            read_addr(written[rand_bits(4) % written.size()], s);
            check_value("req_ready stalls", 0, s);
        end
        go_idle(2);
        drain_rsp();
        $display("test back_to_back done, %0d errors", errors - e0);
    endtask

    task automatic test_write_then_read();
        int e0;
        int s;
        logic [ADDR_W-1:0] a;
        e0 = errors;
        write_new(a);
        go_idle(4);
        send_req(make_req(OP_WRITE, a, rand_bits(DATA_W), '0), s);
        read_addr(a, s);
        go_idle(2);
        drain_rsp();
        $display("test write_then_read done, %0d errors", errors - e0);
    endtask

    task automatic test_back_pressure();
        int e0;
        int s;
        logic [ADDR_W-1:0] addrs [6];
        logic [ADDR_W-1:0] a;
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            write_new(addrs[i]);
        end
        go_idle(4);
        rsp_ready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            read_addr(addrs[i], s);
            check_value("read stalls", 0, s);
        end
        // fifth read must wait for a credit
        @(negedge clk);
        req = make_req(OP_READ, addrs[4], '0, next_tag);
        repeat (3) begin
            @(posedge clk);
            check_value("req_ready", 0, req_ready);
        end
        go_idle(1);
        a = rand_bits(ADDR_W);
        send_req(make_req(OP_WRITE, a, rand_bits(DATA_W), '0), s);
        check_value("write stalls", 0, s);
        go_idle(3);
        rsp_ready = 1'b1;
        read_addr(addrs[4], s);
        read_addr(addrs[5], s);
        go_idle(2);
        drain_rsp();
        $display("test back_pressure done, %0d errors", errors - e0);
    endtask

    initial begin
        lfsr      = 32'd10;
        next_tag  = '0;
        errors    = 0;
        checks    = 0;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        test_reset_values();
        test_single_read();
        test_back_to_back();
        test_write_then_read();
        test_back_pressure();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/zbt_sram_model.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipelined NoBL SRAM model
// read and write data both two edges after the command
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module zbt_sram_model
    import sram_cfg_pkg::*;
    import sram_req_pkg::*;
(
    input  logic              clk,
    input  sram_cmd_t         sram_cmd,
    inout  wire  [DATA_W-1:0] sram_data
);

    logic [DATA_W-1:0] mem [1 << ADDR_W];

    // commands sampled one and two edges ago
    sram_cmd_t         cmd_d1;
    sram_cmd_t         cmd_d2;

    logic [DATA_W-1:0] rd_word;
    logic              rd_drive;

    initial begin
        cmd_d1   = '{addr: '0, we_n: 1'b1};
        cmd_d2   = '{addr: '0, we_n: 1'b1};
        rd_word  = '0;
        rd_drive = 1'b0;
    end

    // outputs stay off in a slot that carries write data
    assign sram_data = rd_drive ? rd_word : 'z;

    always @(posedge clk) begin
        if (!cmd_d2.we_n) begin
            mem[cmd_d2.addr] = sram_data;
        end
        // a read looked up here already sees a write stored on this edge
        rd_word  <= mem[cmd_d1.addr];
        rd_drive <= cmd_d1.we_n;
        cmd_d2   <= cmd_d1;
        cmd_d1   <= sram_cmd;
    end

endmodule

//--- rtl/zbt_sram_ctrl.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ZBT SRAM controller top
// request, command and data stages to SRAM pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module zbt_sram_ctrl
    import sram_cfg_pkg::*;
    import sram_req_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_valid,
    input  sram_req_t         req,
    output logic              req_ready,
    output logic              rsp_valid,
    output sram_rsp_t         rsp,
    input  logic              rsp_ready,
    output sram_cmd_t         sram_cmd,
    inout  wire  [DATA_W-1:0] sram_data
);

    logic              issue_valid;
    sram_req_t         issue_req;
    logic              wr_valid;
    logic [DATA_W-1:0] wr_data;
    logic              rd_valid;
    logic [TAG_W-1:0]  rd_tag;
    logic              rsp_pop;

    zbt_req_stage u_req_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .rsp_pop     (rsp_pop),
        .issue_valid (issue_valid),
        .issue_req   (issue_req)
    );

    zbt_cmd_stage u_cmd_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .sram_cmd    (sram_cmd),
        .wr_valid    (wr_valid),
        .wr_data     (wr_data),
        .rd_valid    (rd_valid),
        .rd_tag      (rd_tag)
    );

    zbt_data_stage u_data_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_valid    (wr_valid),
        .wr_data     (wr_data),
        .rd_valid    (rd_valid),
        .rd_tag      (rd_tag),
        .sram_data   (sram_data),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .rsp_ready   (rsp_ready),
        .rsp_pop     (rsp_pop)
    );

endmodule

//--- rtl/zbt_data_stage.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ZBT data stage
// drives write data, captures reads into a FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module zbt_data_stage
    import sram_cfg_pkg::*;
    import sram_req_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wr_valid,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              rd_valid,
    input  logic [TAG_W-1:0]  rd_tag,
    inout  wire  [DATA_W-1:0] sram_data,
    output logic              rsp_valid,
    output sram_rsp_t         rsp,
    input  logic              rsp_ready,
    output logic              rsp_pop
);

    // write side
    logic              oe_q;
    logic [DATA_W-1:0] dout_q;

    // read tag delay line, lines up with bus data
    logic              rd_valid_d1;
    logic              rd_valid_d2;
    logic [TAG_W-1:0]  rd_tag_d1;
    logic [TAG_W-1:0]  rd_tag_d2;
    logic [DATA_W-1:0] rdata_q;

    // response FIFO
    sram_rsp_t         fifo_mem [RSP_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;

    // bus is ours only while the registered enable is high
    assign sram_data = oe_q ? dout_q : 'z;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            oe_q        <= 1'b0;
            rd_valid_d1 <= 1'b0;
            rd_valid_d2 <= 1'b0;
        end else begin
            oe_q        <= wr_valid;
            rd_valid_d1 <= rd_valid;
            rd_valid_d2 <= rd_valid_d1;
        end
    end

    always_ff @(posedge clk) begin
        dout_q    <= wr_data;
        rdata_q   <= sram_data;
        rd_tag_d1 <= rd_tag;
        rd_tag_d2 <= rd_tag_d1;
    end

    // SRAM word is on the bus while rd_valid_d1 is high
    // and sits in rdata_q when the FIFO takes it
    assign push      = rd_valid_d2;
    assign rsp_valid = (count != '0);
    assign rsp       = fifo_mem[rd_ptr];
    assign rsp_pop   = rsp_valid && rsp_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= '{rdata: rdata_q, tag: rd_tag_d2};
        end
    end

    // credits upstream keep push from hitting a full FIFO
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rsp_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, rsp_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/zbt_cmd_stage.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ZBT command stage
// SRAM address/write-enable and the data-side delay
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module zbt_cmd_stage
    import sram_cfg_pkg::*;
    import sram_req_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue_valid,
    input  sram_req_t         issue_req,
    output sram_cmd_t         sram_cmd,
    output logic              wr_valid,
    output logic [DATA_W-1:0] wr_data,
    output logic              rd_valid,
    output logic [TAG_W-1:0]  rd_tag
);

    logic [ADDR_W-1:0] cmd_addr_q;
    logic              cmd_we_n_q;
    logic              cmd_rd_q;
    logic [DATA_W-1:0] cmd_wdata_q;
    logic [TAG_W-1:0]  cmd_tag_q;

    assign sram_cmd = '{addr: cmd_addr_q, we_n: cmd_we_n_q};

    // idle cycles go out as reads that nobody captures
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_we_n_q <= 1'b1;
            cmd_rd_q   <= 1'b0;
            wr_valid   <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            cmd_we_n_q <= !(issue_valid && (issue_req.op == OP_WRITE));
            cmd_rd_q   <= issue_valid && (issue_req.op == OP_READ);
            // one edge after the command goes out on the pins
            wr_valid   <= !cmd_we_n_q;
            rd_valid   <= cmd_rd_q;
        end
    end

    always_ff @(posedge clk) begin
        cmd_addr_q  <= issue_req.addr;
        cmd_wdata_q <= issue_req.wdata;
        cmd_tag_q   <= issue_req.tag;
        wr_data     <= cmd_wdata_q;
        rd_tag      <= cmd_tag_q;
    end

endmodule

//--- rtl/zbt_req_stage.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ZBT request stage
// issue register and read-credit flow control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module zbt_req_stage
    import sram_cfg_pkg::*;
    import sram_req_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    input  sram_req_t  req,
    output logic       req_ready,
    input  logic       rsp_pop,
    output logic       issue_valid,
    output sram_req_t  issue_req
);

    logic [CNT_W-1:0] credits;
    logic             accept;
    logic             take_credit;

    // writes never wait, reads need a free FIFO slot
    assign req_ready   = (credits != '0) || (req.op == OP_WRITE);
    assign accept      = req_valid && req_ready;
    assign take_credit = accept && (req.op == OP_READ);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits     <= CNT_W'(RSP_FIFO_DEPTH);
            issue_valid <= 1'b0;
        end else begin
            // take and return may land on the same edge
            credits     <= credits + CNT_W'(rsp_pop) - CNT_W'(take_credit);
            issue_valid <= accept;
        end
    end

    // payload only, qualified by issue_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_req <= req;
        end
    end

endmodule

//--- rtl/sram_req_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ZBT SRAM controller transaction types
// opcode, client request/response and SRAM command
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sram_req_pkg;

    import sram_cfg_pkg::*;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } sram_op_e;

    // client request, wdata ignored on reads
    typedef struct packed {
        sram_op_e            op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
        logic [TAG_W-1:0]    tag;
    } sram_req_t;

    // read response
    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        logic [TAG_W-1:0]    tag;
    } sram_rsp_t;

    // what the SRAM samples each cycle, we_n is active low
    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic                we_n;
    } sram_cmd_t;

endpackage

//--- rtl/sram_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ZBT SRAM controller configuration
// bus widths, FIFO depth and pipeline latencies
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sram_cfg_pkg;

    // SRAM pins and client tag
    localparam int ADDR_W = 20;
    localparam int DATA_W = 18;
    localparam int TAG_W  = 4;

    // response FIFO entries, also the number of read credits
    localparam int RSP_FIFO_DEPTH = 4;
    localparam int PTR_W          = $clog2(RSP_FIFO_DEPTH);
    localparam int CNT_W          = $clog2(RSP_FIFO_DEPTH + 1);

    // SRAM command sample to write data sample
    localparam int WR_DATA_DELAY = 2;
    // accept edge to rsp_valid with an empty FIFO
    localparam int READ_LATENCY  = 5;

endpackage
